// ==== include/parser_settings.svh ====
/*
 * Frame geometry and option limits for the options parser
 */
`ifndef PARSER_SETTINGS_SVH
`define PARSER_SETTINGS_SVH

// words in one frame
`define FRAME_WORDS 15

// largest data length, also the number of data slots
`define MAX_DATA 5

// width of a single frame word
`define WORD_WIDTH 32

`endif

// ==== logic/frameTypesPkg.sv ====
/*
 * Frame-level types: word, scan index, whole frame,
 * option codes as they appear in the frame, option kinds of recorded fields
 */
`include "parser_settings.svh"

package frameTypesPkg;

    // one word of the incoming frame
    typedef logic [`WORD_WIDTH-1:0] wordT;

    // position of a word inside the frame
    typedef logic [$clog2(`FRAME_WORDS)-1:0] indexT;

    // whole frame, word i sits at frame[i]
    typedef wordT [`FRAME_WORDS-1:0] frameT;

    // codes found in the frame words
    typedef enum logic [`WORD_WIDTH-1:0] {
        START = 1,
        END   = 2,
        INFO  = 3,
        DATA  = 4
    } optionCodeE;

    // kind tag stored with each recorded field
    typedef enum logic [2:0] {
        KIND_START         = 3'd0,
        KIND_END           = 3'd1,
        KIND_INFO          = 3'd2,
        KIND_INFO_CONTENTS = 3'd3,
        KIND_DATA          = 3'd4,
        KIND_DATA_LEN      = 3'd5,
        KIND_DATA_CONTENTS = 3'd6
    } optionKindE;

endpackage

// ==== logic/parseTypesPkg.sv ====
/*
 * Parse result types and scanner control: field, parsed record,
 * data slot counter, scanner states and the record command
 */
`include "parser_settings.svh"

package parseTypesPkg;

    // one recorded option: kind, where it was found, and the word value
    typedef struct packed {
        frameTypesPkg::optionKindE kind;
        frameTypesPkg::indexT      position;
        frameTypesPkg::wordT       contents;
    } fieldT;

    // counts data contents, 0 up to MAX_DATA
    typedef logic [$clog2(`MAX_DATA+1)-1:0] slotCountT;

    // complete result of one parse
    typedef struct packed {
        fieldT                     startOpt;
        fieldT                     endOpt;
        fieldT                     infoOpt;
        fieldT                     infoContents;
        fieldT                     dataOpt;
        fieldT                     dataLen;
        fieldT [`MAX_DATA-1:0]     dataContents;
        logic                      hasStart;
        logic                      hasInfo;
        logic                      hasData;
        logic                      hasEnd;
        logic                      isEmpty;
        logic                      hasError;
    } parsedOptionsT;

    // scanner FSM
    typedef enum logic [2:0] {
        READY,
        SCAN,
        DATALEN,
        DATABODY,
        DONE
    } scanStateE;

    // scanner to recorder, at most one per cycle
    // flag requests are honoured even without valid
    typedef struct packed {
        logic                      valid;
        frameTypesPkg::optionKindE kind;
        frameTypesPkg::indexT      position;
        frameTypesPkg::wordT       contents;
        logic                      setError;
        logic                      setEmpty;
    } recordCmdT;

endpackage

// ==== logic/frameBuffer.sv ====
/*
 * Frame capture register with current and next word select
 */
`include "parser_settings.svh"

module frameBuffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                capture,
    input  frameTypesPkg::frameT frameIn,
    input  frameTypesPkg::indexT scanIndex,
    output frameTypesPkg::wordT  curWord,
    output frameTypesPkg::wordT  nextWord
);

    frameTypesPkg::frameT frame;

    // one bit wider so the last index plus one does not wrap
    logic [$clog2(`FRAME_WORDS):0] nextIndex;

    // frame held for the whole parse, input is free to change
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame <= '0;
        end else if (capture) begin
            frame <= frameIn;
        end
    end

    assign nextIndex = {1'b0, scanIndex} + 1'b1;

    always_comb begin
        curWord  = '0;
        nextWord = '0;
        if (scanIndex < `FRAME_WORDS) begin
            curWord = frame[scanIndex];
        end
        // past the last word reads as zero
        if (nextIndex < `FRAME_WORDS) begin
            nextWord = frame[nextIndex];
        end
    end

endmodule

// ==== logic/optionScanner.sv ====
/*
 * Scanner FSM: walks the captured frame one word per cycle, checks limits,
 * drives busy/done/ready and sends record commands
 */
`include "parser_settings.svh"

module optionScanner (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         startParsing,
    input  logic                         read,
    input  frameTypesPkg::wordT          curWord,
    input  frameTypesPkg::wordT          nextWord,
    input  parseTypesPkg::parsedOptionsT parsed,
    output logic                         capture,
    output logic                         clearRecord,
    output frameTypesPkg::indexT         scanIndex,
    output parseTypesPkg::recordCmdT     cmd,
    output logic                         busy,
    output logic                         done,
    output logic                         ready
);

    // highest legal positions for info and data words, last legal data contents
    localparam int INFO_LAST = `FRAME_WORDS - 3;
    localparam int DATA_LAST = `FRAME_WORDS - 4;
    localparam int LEN_LIMIT = `FRAME_WORDS - 2;

    parseTypesPkg::scanStateE state;
    parseTypesPkg::scanStateE stateNext;
    frameTypesPkg::indexT     indexNext;
    parseTypesPkg::slotCountT dataCount;
    parseTypesPkg::slotCountT dataCountNext;
    logic                     infoPending;
    logic                     infoPendingNext;
    logic                     lastWord;
    logic                     stop;

    function automatic parseTypesPkg::recordCmdT fieldCmd(
        input frameTypesPkg::optionKindE kind,
        input frameTypesPkg::indexT      position,
        input frameTypesPkg::wordT       contents
    );
        parseTypesPkg::recordCmdT c;
        c          = '0;
        c.valid    = 1'b1;
        c.kind     = kind;
        c.position = position;
        c.contents = contents;
        return c;
    endfunction

    assign lastWord = (scanIndex == `FRAME_WORDS - 1);

    always_comb begin
        stateNext       = state;
        indexNext       = scanIndex;
        dataCountNext   = dataCount;
        infoPendingNext = infoPending;
        cmd             = '0;
        capture         = 1'b0;
        clearRecord     = 1'b0;
        stop            = 1'b0;

        case (state)
            parseTypesPkg::READY: begin
                if (startParsing) begin
                    capture         = 1'b1;
                    clearRecord     = 1'b1;
                    indexNext       = '0;
                    infoPendingNext = 1'b0;
                    stateNext       = parseTypesPkg::SCAN;
                end
            end

            parseTypesPkg::SCAN: begin
                if (infoPending) begin
                    // info word recorded last cycle, its contents follow it
                    cmd = fieldCmd(frameTypesPkg::KIND_INFO_CONTENTS,
                                   scanIndex + 1'b1, nextWord);
                    indexNext       = scanIndex + 2'd2;
                    infoPendingNext = 1'b0;
                end else begin
                    indexNext = scanIndex + 1'b1;
                    if (curWord == frameTypesPkg::START) begin
                        // a later start just moves the start position
                        cmd = fieldCmd(frameTypesPkg::KIND_START, scanIndex, curWord);
                    end else if (parsed.hasStart) begin
                        if (curWord == frameTypesPkg::END) begin
                            cmd = fieldCmd(frameTypesPkg::KIND_END, scanIndex, curWord);
                            cmd.setEmpty = !parsed.hasInfo && !parsed.hasData;
                            stop = 1'b1;
                        end else if (curWord == frameTypesPkg::INFO && !parsed.hasInfo) begin
                            if (scanIndex > INFO_LAST) begin
                                cmd.setError = 1'b1;
                                stop = 1'b1;
                            end else begin
                                cmd = fieldCmd(frameTypesPkg::KIND_INFO, scanIndex, curWord);
                                indexNext       = scanIndex;
                                infoPendingNext = 1'b1;
                            end
                        end else if (curWord == frameTypesPkg::DATA && !parsed.hasData) begin
                            if (scanIndex > DATA_LAST) begin
                                cmd.setError = 1'b1;
                                stop = 1'b1;
                            end else begin
                                cmd = fieldCmd(frameTypesPkg::KIND_DATA, scanIndex, curWord);
                                stateNext = parseTypesPkg::DATALEN;
                            end
                        end
                    end
                    // frame ran out without an end word
                    if (lastWord && !stop) begin
                        stop = 1'b1;
                        if (parsed.hasStart || curWord == frameTypesPkg::START) begin
                            cmd.setError = 1'b1;
                        end else begin
                            cmd.setEmpty = 1'b1;
                        end
                    end
                end
            end

            parseTypesPkg::DATALEN: begin
                cmd = fieldCmd(frameTypesPkg::KIND_DATA_LEN, scanIndex, curWord);
                indexNext = scanIndex + 1'b1;
                // length above MAX_DATA is checked first, so the sum cannot wrap
                if (curWord > `MAX_DATA ||
                    frameTypesPkg::wordT'(scanIndex) + curWord > LEN_LIMIT) begin
                    cmd.setError = 1'b1;
                    stop = 1'b1;
                end else if (curWord == '0) begin
                    stateNext = parseTypesPkg::SCAN;
                end else begin
                    dataCountNext = curWord[$bits(parseTypesPkg::slotCountT)-1:0];
                    stateNext     = parseTypesPkg::DATABODY;
                end
            end

            parseTypesPkg::DATABODY: begin
                cmd = fieldCmd(frameTypesPkg::KIND_DATA_CONTENTS, scanIndex, curWord);
                indexNext     = scanIndex + 1'b1;
                dataCountNext = dataCount - 1'b1;
                if (dataCount == 1) begin
                    stateNext = parseTypesPkg::SCAN;
                end
            end

            parseTypesPkg::DONE: begin
                if (read && done) begin
                    stateNext = parseTypesPkg::READY;
                end
            end

            default: begin
                stateNext = parseTypesPkg::READY;
            end
        endcase

        if (stop) begin
            stateNext = parseTypesPkg::DONE;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= parseTypesPkg::READY;
            scanIndex   <= '0;
            dataCount   <= '0;
            infoPending <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
            ready       <= 1'b1;
        end else begin
            state       <= stateNext;
            scanIndex   <= indexNext;
            dataCount   <= dataCountNext;
            infoPending <= infoPendingNext;
            ready       <= (stateNext == parseTypesPkg::READY);
            done        <= (stateNext == parseTypesPkg::DONE);
            // busy overlaps done only in its first cycle
            busy        <= (stateNext == parseTypesPkg::SCAN) ||
                           (stateNext == parseTypesPkg::DATALEN) ||
                           (stateNext == parseTypesPkg::DATABODY) ||
                           (stateNext == parseTypesPkg::DONE &&
                            state != parseTypesPkg::DONE);
        end
    end

    doneBusyOverlap: assert property (
        @(posedge clk) disable iff (rst)
        (done && busy) |=> !busy
    ) else $error("busy still high one cycle after done rose");

    scanInRange: assert property (
        @(posedge clk) disable iff (rst)
        (state == parseTypesPkg::SCAN) |-> (scanIndex <= `FRAME_WORDS - 1)
    ) else $error("scan index beyond last frame word");

endmodule

// ==== logic/optionRecorder.sv ====
/*
 * Parsed record storage, written one field per command
 */
`include "parser_settings.svh"

module optionRecorder (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         clearRecord,
    input  parseTypesPkg::recordCmdT     cmd,
    output parseTypesPkg::parsedOptionsT parsed
);

    parseTypesPkg::fieldT     newField;
    // next free data contents slot
    parseTypesPkg::slotCountT slot;

    assign newField = '{kind: cmd.kind, position: cmd.position, contents: cmd.contents};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            parsed <= '0;
            slot   <= '0;
        end else if (clearRecord) begin
            parsed <= '0;
            slot   <= '0;
        end else begin
            if (cmd.valid) begin
                case (cmd.kind)
                    frameTypesPkg::KIND_START: begin
                        parsed.startOpt <= newField;
                        parsed.hasStart <= 1'b1;
                    end
                    frameTypesPkg::KIND_END: begin
                        parsed.endOpt <= newField;
                        parsed.hasEnd <= 1'b1;
                    end
                    frameTypesPkg::KIND_INFO: begin
                        parsed.infoOpt <= newField;
                        parsed.hasInfo <= 1'b1;
                    end
                    frameTypesPkg::KIND_INFO_CONTENTS: begin
                        parsed.infoContents <= newField;
                    end
                    frameTypesPkg::KIND_DATA: begin
                        parsed.dataOpt <= newField;
                        parsed.hasData <= 1'b1;
                    end
                    frameTypesPkg::KIND_DATA_LEN: begin
                        parsed.dataLen <= newField;
                    end
                    frameTypesPkg::KIND_DATA_CONTENTS: begin
                        // contents land in arrival order
                        parsed.dataContents[slot] <= newField;
                        slot <= slot + 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            if (cmd.setError) begin
                parsed.hasError <= 1'b1;
            end
            if (cmd.setEmpty) begin
                parsed.isEmpty <= 1'b1;
            end
        end
    end

    slotInRange: assert property (
        @(posedge clk) disable iff (rst)
        (!clearRecord && cmd.valid && cmd.kind == frameTypesPkg::KIND_DATA_CONTENTS)
            |-> (slot < `MAX_DATA)
    ) else $error("data contents write past the last slot");

endmodule

// ==== logic/optionsParser.sv ====
/*
 * Options parser top: frame buffer, scanner FSM and record storage
 */
module optionsParser (
    input  logic                         clk,
    input  logic                         rst,
    input  frameTypesPkg::frameT         frameIn,
    input  logic                         startParsing,
    input  logic                         read,
    output parseTypesPkg::parsedOptionsT parsed,
    output logic                         busy,
    output logic                         done,
    output logic                         ready
);

    logic                     capture;
    logic                     clearRecord;
    frameTypesPkg::indexT     scanIndex;
    frameTypesPkg::wordT      curWord;
    frameTypesPkg::wordT      nextWord;
    parseTypesPkg::recordCmdT cmd;

    frameBuffer u_frameBuffer (
        .clk      (clk),
        .rst      (rst),
        .capture  (capture),
        .frameIn  (frameIn),
        .scanIndex(scanIndex),
        .curWord  (curWord),
        .nextWord (nextWord)
    );

    // scanner reads back the recorded flags
    optionScanner u_optionScanner (
        .clk         (clk),
        .rst         (rst),
        .startParsing(startParsing),
        .read        (read),
        .curWord     (curWord),
        .nextWord    (nextWord),
        .parsed      (parsed),
        .capture     (capture),
        .clearRecord (clearRecord),
        .scanIndex   (scanIndex),
        .cmd         (cmd),
        .busy        (busy),
        .done        (done),
        .ready       (ready)
    );

    optionRecorder u_optionRecorder (
        .clk        (clk),
        .rst        (rst),
        .clearRecord(clearRecord),
        .cmd        (cmd),
        .parsed     (parsed)
    );

endmodule

// ==== sim/parseChecker.sv ====
/*
 * Testbench checker: reference parse of the captured frame,
 * record comparison on each rising done, handshake timing checks
 */
`include "parser_settings.svh"

module parseChecker (
    input  logic                         clk,
    input  logic                         rst,
    input  frameTypesPkg::frameT         frameIn,
    input  logic                         startParsing,
    input  logic                         read,
    input  parseTypesPkg::parsedOptionsT parsed,
    input  logic                         busy,
    input  logic                         done,
    input  logic                         ready,
    output int                           errorCount,
    output int                           checkCount
);

    // last legal positions for info and data words, last legal data contents
    localparam int INFO_MAX_POS = 12;
    localparam int DATA_MAX_POS = 11;
    localparam int LEN_MAX_END  = 13;

    frameTypesPkg::frameT         keptFrame;
    parseTypesPkg::parsedOptionsT heldParsed;
    logic                         prevRst;
    logic                         prevAccept;
    logic                         prevDone;
    logic                         prevRead;
    logic                         doneRose;

    function automatic parseTypesPkg::fieldT makeField(
        input frameTypesPkg::optionKindE kind,
        input int                        pos,
        input frameTypesPkg::wordT       value
    );
        parseTypesPkg::fieldT fld;
        fld.kind     = kind;
        fld.position = frameTypesPkg::indexT'(pos);
        fld.contents = value;
        return fld;
    endfunction

    function automatic parseTypesPkg::parsedOptionsT refParse(input frameTypesPkg::frameT f);
        parseTypesPkg::parsedOptionsT r;
        int                           i;
        int                           k;
        int                           len;
        logic                         finished;
        r        = '0;
        i        = 0;
        finished = 1'b0;
        while (!finished) begin
            if (i >= `FRAME_WORDS) begin
                // frame ran out, error only once a start was seen
                r.hasError = r.hasStart;
                r.isEmpty  = !r.hasStart;
                finished   = 1'b1;
            end else if (f[i] == 1) begin
                r.startOpt = makeField(frameTypesPkg::KIND_START, i, f[i]);
                r.hasStart = 1'b1;
                i++;
            end else if (!r.hasStart) begin
                i++;
            end else if (f[i] == 2) begin
                r.endOpt  = makeField(frameTypesPkg::KIND_END, i, f[i]);
                r.hasEnd  = 1'b1;
                r.isEmpty = !r.hasInfo && !r.hasData;
                finished  = 1'b1;
            end else if (f[i] == 3 && !r.hasInfo) begin
                if (i > INFO_MAX_POS) begin
                    r.hasError = 1'b1;
                    finished   = 1'b1;
                end else begin
                    r.infoOpt      = makeField(frameTypesPkg::KIND_INFO, i, f[i]);
                    r.infoContents = makeField(frameTypesPkg::KIND_INFO_CONTENTS, i + 1, f[i + 1]);
                    r.hasInfo      = 1'b1;
                    i += 2;
                end
            end else if (f[i] == 4 && !r.hasData) begin
                if (i > DATA_MAX_POS) begin
                    r.hasError = 1'b1;
                    finished   = 1'b1;
                end else begin
                    r.dataOpt = makeField(frameTypesPkg::KIND_DATA, i, f[i]);
                    r.hasData = 1'b1;
                    r.dataLen = makeField(frameTypesPkg::KIND_DATA_LEN, i + 1, f[i + 1]);
                    if (f[i + 1] > `MAX_DATA || i + 1 + f[i + 1] > LEN_MAX_END) begin
                        // option and length stay, no contents
                        r.hasError = 1'b1;
                        finished   = 1'b1;
                    end else begin
                        len = int'(f[i + 1]);
                        for (k = 0; k < len; k++) begin
                            r.dataContents[k] = makeField(frameTypesPkg::KIND_DATA_CONTENTS,
                                                          i + 2 + k, f[i + 2 + k]);
                        end
                        i = i + 2 + len;
                    end
                end
            end else begin
                i++;
            end
        end
        return r;
    endfunction

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errorCount++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic checkField(input string name, input parseTypesPkg::fieldT exp,
                              input parseTypesPkg::fieldT act);
        if (act !== exp) begin
            errorCount++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic compareRecord(input parseTypesPkg::parsedOptionsT exp,
                                 input parseTypesPkg::parsedOptionsT act);
        checkField("parsed.startOpt", exp.startOpt, act.startOpt);
        checkField("parsed.endOpt", exp.endOpt, act.endOpt);
        checkField("parsed.infoOpt", exp.infoOpt, act.infoOpt);
        checkField("parsed.infoContents", exp.infoContents, act.infoContents);
        checkField("parsed.dataOpt", exp.dataOpt, act.dataOpt);
        checkField("parsed.dataLen", exp.dataLen, act.dataLen);
        for (int k = 0; k < `MAX_DATA; k++) begin
            checkField($sformatf("parsed.dataContents[%0d]", k),
                       exp.dataContents[k], act.dataContents[k]);
        end
        checkBit("parsed.hasStart", exp.hasStart, act.hasStart);
        checkBit("parsed.hasInfo", exp.hasInfo, act.hasInfo);
        checkBit("parsed.hasData", exp.hasData, act.hasData);
        checkBit("parsed.hasEnd", exp.hasEnd, act.hasEnd);
        checkBit("parsed.isEmpty", exp.isEmpty, act.isEmpty);
        checkBit("parsed.hasError", exp.hasError, act.hasError);
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        keptFrame  = '0;
        heldParsed = '0;
        prevRst    = 1'b0;
    end

    always @(posedge clk) begin
        if (rst) begin
            prevRst    = 1'b1;
            prevAccept = 1'b0;
            prevDone   = 1'b0;
            prevRead   = 1'b0;
            doneRose   = 1'b0;
        end else begin
            // first cycle out of reset still shows the reset state
            if (prevRst) begin
                checkBit("ready", 1'b1, ready);
                checkBit("busy", 1'b0, busy);
                checkBit("done", 1'b0, done);
            end
            if (prevAccept) begin
                checkBit("busy", 1'b1, busy);
                checkBit("ready", 1'b0, ready);
            end
            // busy drops one cycle after done rises
            if (doneRose) begin
                checkBit("busy", 1'b0, busy);
            end
            if (prevDone && prevRead) begin
                checkBit("done", 1'b0, done);
                checkBit("ready", 1'b1, ready);
            end else if (prevDone) begin
                checkBit("done", 1'b1, done);
                if (parsed !== heldParsed) begin
                    errorCount++;
                    $display("** Error at %0t: parsed expected %h, got %h",
                             $time, heldParsed, parsed);
                end
            end
            doneRose = done && !prevDone;
            if (doneRose) begin
                // busy still up in the cycle done rises
                checkBit("busy", 1'b1, busy);
                compareRecord(refParse(keptFrame), parsed);
                checkCount++;
            end
            if (ready && startParsing) begin
                keptFrame = frameIn;
            end
            prevRst    = 1'b0;
            prevAccept = ready && startParsing;
            prevDone   = done;
            prevRead   = read;
            heldParsed = parsed;
        end
    end

endmodule

// ==== sim/optionsParserTb.sv ====
/*
 * Testbench top: clock, reset, directed and LFSR frames,
 * handshake driving and watchdog
 */
`include "parser_settings.svh"

module optionsParserTb;

    localparam int PERIOD          = 40;
    localparam int DIRECTED_FRAMES = 10;
    localparam int RANDOM_FRAMES   = 400;
    localparam int TIMEOUT_CYCLES  = (DIRECTED_FRAMES + RANDOM_FRAMES) * 20 + 500;

    logic                         clk;
    logic                         rst;
    frameTypesPkg::frameT         frameIn;
    logic                         startParsing;
    logic                         read;
    parseTypesPkg::parsedOptionsT parsed;
    logic                         busy;
    logic                         done;
    logic                         ready;
    int                           errorCount;
    int                           checkCount;
    int                           framesRun;
    logic [31:0]                  lfsrState;

    optionsParser u_optionsParser (
        .clk         (clk),
        .rst         (rst),
        .frameIn     (frameIn),
        .startParsing(startParsing),
        .read        (read),
        .parsed      (parsed),
        .busy        (busy),
        .done        (done),
        .ready       (ready)
    );

    parseChecker u_parseChecker (
        .clk         (clk),
        .rst         (rst),
        .frameIn     (frameIn),
        .startParsing(startParsing),
        .read        (read),
        .parsed      (parsed),
        .busy        (busy),
        .done        (done),
        .ready       (ready),
        .errorCount  (errorCount),
        .checkCount  (checkCount)
    );

    always #(PERIOD / 2) clk = ~clk;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int b = 0; b < n; b++) begin
            bits      = {bits[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return bits;
    endfunction

    // one hex digit per word, word 0 is the leftmost digit
    function automatic frameTypesPkg::frameT frameOf(input logic [59:0] digits);
        frameTypesPkg::frameT f;
        for (int i = 0; i < `FRAME_WORDS; i++) begin
            f[i] = frameTypesPkg::wordT'(digits[59 - 4 * i -: 4]);
        end
        return f;
    endfunction

    function automatic frameTypesPkg::frameT randomFrame();
        frameTypesPkg::frameT f;
        for (int i = 0; i < `FRAME_WORDS; i++) begin
            // mostly codes and small lengths, now and then a large word
            if (randBits(4) == 4'hf) begin
                f[i] = randBits(32);
            end else begin
                f[i] = randBits(3) % 6;
            end
        end
        return f;
    endfunction

    // entered just after an edge with ready high
    task automatic runFrame(input frameTypesPkg::frameT f, input int holdCycles,
                            input logic pokeStart);
        frameIn      = f;
        startParsing = 1'b1;
        @(posedge clk);
        #2;
        startParsing = 1'b0;
        // frame is captured, input may now change
        frameIn = ~f;
        while (!done) begin
            @(posedge clk);
            #2;
        end
        repeat (holdCycles) begin
            startParsing = pokeStart;
            @(posedge clk);
            #2;
        end
        startParsing = 1'b0;
        read         = 1'b1;
        @(posedge clk);
        #2;
        read = 1'b0;
        framesRun++;
    endtask

    initial begin : watchdog
        #(TIMEOUT_CYCLES * PERIOD);
        $display("timeout: the parses did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : stimulus
        frameTypesPkg::frameT f;
        int                   hold;
        logic                 poke;
        clk          = 1'b0;
        rst          = 1'b1;
        frameIn      = '0;
        startParsing = 1'b0;
        read         = 1'b0;
        framesRun    = 0;
        lfsrState    = 32'h721;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        runFrame(frameOf(60'h0139_4378_9200_000), 0, 1'b0);
        runFrame(frameOf(60'h0234_5000_0000_000), 2, 1'b1);
        runFrame(frameOf(60'h1200_0000_0000_000), 1, 1'b0);
        runFrame(frameOf(60'h1035_0000_0000_000), 3, 1'b1);
        // length above the limit, then a length that overruns
        runFrame(frameOf(60'h1460_0000_0000_002), 0, 1'b0);
        runFrame(frameOf(60'h1000_0000_0440_000), 4, 1'b1);
        runFrame(frameOf(60'h1000_0000_0000_030), 1, 1'b0);
        runFrame(frameOf(60'h1353_6404_2000_000), 2, 1'b1);
        runFrame(frameOf(60'h1103_0000_0000_012), 0, 1'b0);
        runFrame(frameOf(60'h1000_0004_5678_9A2), 5, 1'b1);

        for (int n = 0; n < RANDOM_FRAMES; n++) begin
            f    = randomFrame();
            hold = int'(randBits(2));
            poke = (randBits(1) != '0);
            runFrame(f, hold, poke);
        end

        if (checkCount != framesRun) begin
            $display("done rose %0d times for %0d frames", checkCount, framesRun);
        end
        $display("frames %0d, records checked %0d, errors %0d",
                 framesRun, checkCount, errorCount);
        if (errorCount == 0 && checkCount == framesRun) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
logic/frameTypesPkg.sv
logic/parseTypesPkg.sv
logic/frameBuffer.sv
logic/optionScanner.sv
logic/optionRecorder.sv
logic/optionsParser.sv
sim/parseChecker.sv
sim/optionsParserTb.sv

// ==== Bender.yml ====
package:
  name: options_parser

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/frameTypesPkg.sv
      - logic/parseTypesPkg.sv
      - logic/frameBuffer.sv
      - logic/optionScanner.sv
      - logic/optionRecorder.sv
      - logic/optionsParser.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/parseChecker.sv
      - sim/optionsParserTb.sv
